/* src.f */
vmem_pkg.sv
vmem_if.sv
vmem_map.sv
vmem_ctrl.sv
vmem_bus.sv
vmem_top.sv
tb_vmem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_vmem
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) && echo "result: passed" || (echo "result: failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_vmem.sv */
// testbench for the vmem access path covering map loads, reads, writes, denials, stalls and timeout
`timescale 1ns/1ps

module tb_vmem;
   import vmem_pkg::*;

   localparam int tb_timeout = 12;
   localparam int n_tests = 6;
   localparam int max_cycles = n_tests * 200;
   localparam int done_limit = 40;

   logic clk = 1'b0;
   logic reset;
   logic [vma_width-1:0] vma, md, md_read, wb_dat_w, wb_dat_r;
   logic memrd, memwr, ifetch, lcinc, needfetch, map_wr_l1, map_wr_l2;
   logic md_valid, waiting, vmaok, bus_error;
   logic wb_cyc, wb_stb, wb_we, wb_ack;
   logic [phys_adr_bits-1:0] wb_adr;
   phase_t phase;

   // slave memory and the words the processor side has written
   logic [vma_width-1:0] mem [2**phys_adr_bits];
   logic [vma_width-1:0] shadow [logic [phys_adr_bits-1:0]];
   logic silent = 1'b0;
   logic in_cycle;
   int ack_delay = 0;
   int wait_left;

   // what the access in flight should produce
   logic [phys_adr_bits-1:0] exp_adr;
   logic [vma_width-1:0] exp_data;
   logic exp_we, exp_permit, vmaok_due;

   // mapped pages with l1 index, l2 index, level-2 block, page, access and write bits
   logic [l1_index_bits-1:0] pg_l1 [3];
   logic [l2_index_bits-1:0] pg_l2 [3];
   logic [l1_entry_bits-1:0] pg_blk [3];
   logic [page_bits-1:0] pg_page [3];
   logic pg_acc [3];
   logic pg_wr [3];

   logic [31:0] rng = 32'h09f8_aa58;
   int cycles = 0;
   int cyc_len = 0;
   int errors = 0;
   int err_start = 0;
   int test_num = 0;
   int tests_ok = 0;
   int tests_bad = 0;

   vmem_top #(
      .bus_timeout(tb_timeout)
   ) uut (.*);

   always #4 clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // every word differs with the whole address
   function automatic logic [vma_width-1:0] fill_word(input logic [phys_adr_bits-1:0] a);
      return {a[9:0], a} ^ 32'h6b3c_0000;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
      errors = errors + 1;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, expected);
   endtask

   task automatic report_failure(input string what);
      errors = errors + 1;
      $display("t=%0t %s", $time, what);
   endtask

   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic set_page(input int pg, input logic [10:0] l1, input logic [4:0] l2,
                           input logic [4:0] blk, input logic [13:0] page,
                           input logic acc, input logic wr);
      pg_l1[pg] = l1;
      pg_l2[pg] = l2;
      pg_blk[pg] = blk;
      pg_page[pg] = page;
      pg_acc[pg] = acc;
      pg_wr[pg] = wr;
   endtask

   // level-1 goes first so level-2 is written through the new block number
   task automatic load_page(input int pg);
      vma = {8'h00, pg_l1[pg], pg_l2[pg], 8'h00};
      md = {27'h0, pg_blk[pg]};
      map_wr_l1 = 1'b1;
      step();
      map_wr_l1 = 1'b0;
      md = {8'h00, pg_acc[pg], pg_wr[pg], 8'h00, pg_page[pg]};
      map_wr_l2 = 1'b1;
      step();
      map_wr_l2 = 1'b0;
   endtask

   task automatic run_access(input logic wr, input int pg, input logic [7:0] off,
                             input logic [31:0] data);
      logic [phys_adr_bits-1:0] adr;
      int n;
      adr = {pg_page[pg], off};
      step();
      while (phase != alu)
         step();
      exp_adr = adr;
      exp_we = wr;
      exp_permit = pg_acc[pg] & (!wr | pg_wr[pg]);
      exp_data = wr ? data : (shadow.exists(adr) ? shadow[adr] : fill_word(adr));
      vma = {8'h00, pg_l1[pg], pg_l2[pg], off};
      md = data;
      memrd = !wr;
      memwr = wr;
      // strobes held through one machine cycle
      repeat (4) step();
      memrd = 1'b0;
      memwr = 1'b0;
      step();
      vmaok_due = 1'b1;
      step();
      vmaok_due = 1'b0;
      if (exp_permit)
      begin
         n = 0;
         while (!md_valid && !bus_error && n < done_limit)
         begin
            step();
            n++;
         end
         if (n == done_limit)
            report_failure("access never completed");
         else if (silent && !bus_error)
            report_failure("no bus_error after the ack timeout");
         else if (wr)
            shadow[adr] = data;
         while (waiting && n < done_limit)
         begin
            step();
            n++;
         end
      end
   endtask

   task automatic begin_test();
      test_num++;
      err_start = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == err_start)
      begin
         tests_ok++;
         $display("test %0d %s: ok", test_num, name);
      end
      else
      begin
         tests_bad++;
         $display("test %0d %s: failed, %0d errors", test_num, name, errors - err_start);
      end
   endtask

   // slave model acks after ack_delay cycles and never while silent
   initial
   begin
      wb_ack = 1'b0;
      wb_dat_r = '0;
      in_cycle = 1'b0;
      wait_left = 0;
      for (int i = 0; i < 2**phys_adr_bits; i++)
         mem[i] = fill_word(phys_adr_bits'(i));
      forever
      begin
         step();
         wb_ack = 1'b0;
         if (!wb_cyc)
            in_cycle = 1'b0;
         else
         begin
            if (!in_cycle)
            begin
               in_cycle = 1'b1;
               wait_left = ack_delay;
            end
            if (!silent && wait_left == 0)
            begin
               wb_ack = 1'b1;
               if (wb_we)
                  mem[wb_adr] = wb_dat_w;
               else
                  wb_dat_r = mem[wb_adr];
            end
            else if (!silent)
               wait_left = wait_left - 1;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      cyc_len <= wb_cyc ? cyc_len + 1 : 0;
      if (cycles >= max_cycles)
      begin
         $display("run stopped at the cycle limit");
         $display("** FAIL **");
         $finish;
      end
   end

   a_idle: assert property (@(posedge clk) $fell(reset) |->
      !wb_cyc && !waiting && !vmaok && !md_valid && !bus_error)
      else report_failure("outputs not idle after reset");
   a_stb: assert property (@(posedge clk) disable iff (reset) wb_stb == wb_cyc)
      else report_failure("wb_stb does not follow wb_cyc");
   a_adr: assert property (@(posedge clk) disable iff (reset) wb_cyc |-> wb_adr == exp_adr)
      else report_mismatch("wb_adr", 32'($sampled(wb_adr)), 32'(exp_adr));
   a_we: assert property (@(posedge clk) disable iff (reset) wb_cyc |-> wb_we == exp_we)
      else report_mismatch("wb_we", 32'($sampled(wb_we)), 32'(exp_we));
   a_dat_w: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && wb_we |-> wb_dat_w == exp_data)
      else report_mismatch("wb_dat_w", $sampled(wb_dat_w), exp_data);
   a_permit: assert property (@(posedge clk) disable iff (reset) wb_cyc |-> exp_permit)
      else report_failure("bus cycle started for a denied access");
   a_vmaok: assert property (@(posedge clk) disable iff (reset)
      vmaok_due |-> vmaok == exp_permit)
      else report_mismatch("vmaok", 32'($sampled(vmaok)), 32'(exp_permit));
   a_md_read: assert property (@(posedge clk) disable iff (reset)
      md_valid && !exp_we |-> md_read == exp_data)
      else report_mismatch("md_read", $sampled(md_read), exp_data);
   a_mem: assert property (@(posedge clk) disable iff (reset)
      md_valid && exp_we |-> mem[exp_adr] == exp_data)
      else report_mismatch("mem", mem[exp_adr], exp_data);
   a_wait: assert property (@(posedge clk) disable iff (reset) wb_cyc && !wb_ack |-> waiting)
      else report_failure("waiting low during an unanswered bus cycle");
   a_phase: assert property (@(posedge clk) disable iff (reset)
      waiting && $past(waiting) |-> $stable(phase))
      else report_failure("phase moved while waiting");
   a_cyc_len: assert property (@(posedge clk) disable iff (reset) wb_cyc |-> cyc_len <= tb_timeout)
      else report_failure("wb_cyc held past the timeout");
   a_err_once: assert property (@(posedge clk) disable iff (reset) bus_error |=> !bus_error)
      else report_failure("bus_error longer than one cycle");
   a_err_clears: assert property (@(posedge clk) disable iff (reset) bus_error |=> !waiting)
      else report_failure("waiting still high after bus_error");
   a_err_silent: assert property (@(posedge clk) disable iff (reset) bus_error |-> silent)
      else report_failure("bus_error while the slave answers");
   a_valid_silent: assert property (@(posedge clk) disable iff (reset) md_valid |-> !silent)
      else report_failure("md_valid without any ack");

   initial
   begin
      reset = 1'b1;
      vma = '0;
      md = '0;
      {memrd, memwr, ifetch, lcinc, needfetch, map_wr_l1, map_wr_l2} = '0;
      {exp_we, exp_permit, vmaok_due} = '0;
      exp_adr = '0;
      exp_data = '0;
      set_page(0, 11'h123, 5'h04, 5'h03, 14'h1a5b, 1'b1, 1'b0);
      set_page(1, 11'h2f0, 5'h11, 5'h09, 14'h0c3e, 1'b1, 1'b1);
      set_page(2, 11'h055, 5'h1f, 5'h14, 14'h3001, 1'b0, 1'b1);
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      begin_test();
      // also covers the level-2 access clear
      repeat (40) step();
      end_test("idle after reset");

      begin_test();
      for (int pg = 0; pg < 3; pg++)
         load_page(pg);
      run_access(1'b0, 0, 8'h3c, 32'h0);
      run_access(1'b0, 1, 8'ha7, 32'h0);
      end_test("mapped read");

      begin_test();
      run_access(1'b1, 1, 8'h52, 32'hc0de_5a17);
      run_access(1'b0, 1, 8'h52, 32'h0);
      end_test("mapped write");

      begin_test();
      run_access(1'b1, 0, 8'h10, 32'h1234_abcd);
      run_access(1'b0, 2, 8'h20, 32'h0);
      end_test("denied accesses");

      begin_test();
      for (int i = 0; i < 20; i++)
      begin
         rng = lcg_step(rng);
         ack_delay = int'(rng[18:16]) % 6;
         if (rng[5])
            run_access(1'b1, 1, {5'b0, rng[10:8]}, lcg_step(rng));
         else
            run_access(1'b0, int'(rng[12]), {5'b0, rng[10:8]}, 32'h0);
      end
      ack_delay = 0;
      end_test("random ack delays");

      begin_test();
      silent = 1'b1;
      run_access(1'b0, 0, 8'h77, 32'h0);
      silent = 1'b0;
      end_test("ack timeout");

      repeat (3) step();
      $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* vmem_top.sv */
// vmem top: map, control and wishbone master joined behind plain processor ports
`timescale 1ns/1ps

module vmem_top #(
   parameter int bus_timeout = 16
) (
   input  logic clk,
   input  logic reset,
   input  logic [vmem_pkg::vma_width-1:0] vma,
   input  logic [vmem_pkg::vma_width-1:0] md,
   input  logic memrd,
   input  logic memwr,
   input  logic ifetch,
   input  logic lcinc,
   input  logic needfetch,
   input  logic map_wr_l1,
   input  logic map_wr_l2,
   output logic [vmem_pkg::vma_width-1:0] md_read,
   output logic md_valid,
   output logic waiting,
   output logic vmaok,
   output logic bus_error,
   output vmem_pkg::phase_t phase,
   output logic wb_cyc,
   output logic wb_stb,
   output logic wb_we,
   output logic [vmem_pkg::phys_adr_bits-1:0] wb_adr,
   output logic [vmem_pkg::vma_width-1:0] wb_dat_w,
   input  logic [vmem_pkg::vma_width-1:0] wb_dat_r,
   input  logic wb_ack
);

   vmem_map_if map_if ();
   vmem_bus_if bus_if ();

   vmem_map u_map (
      .clk(clk),
      .reset(reset),
      .vma(vma),
      .md(md),
      .memrd(memrd),
      .memwr(memwr),
      .ifetch(ifetch),
      .map_wr_l1(map_wr_l1),
      .map_wr_l2(map_wr_l2),
      .map(map_if.map)
   );

   vmem_ctrl u_ctrl (
      .clk(clk),
      .reset(reset),
      .lcinc(lcinc),
      .needfetch(needfetch),
      .map(map_if.ctrl),
      .bus(bus_if.ctrl),
      .vmaok(vmaok),
      .waiting(waiting),
      .phase(phase)
   );

   vmem_bus #(
      .bus_timeout(bus_timeout)
   ) u_bus (
      .clk(clk),
      .reset(reset),
      .bus(bus_if.bus),
      .wb_cyc(wb_cyc),
      .wb_stb(wb_stb),
      .wb_we(wb_we),
      .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w),
      .wb_dat_r(wb_dat_r),
      .wb_ack(wb_ack),
      .md(md),
      .md_read(md_read),
      .md_valid(md_valid)
   );

   assign bus_error = bus_if.bus_error;

endmodule

/* vmem_bus.sv */
// vmem bus: wishbone classic master with read capture and ack timeout
`timescale 1ns/1ps

module vmem_bus #(
   parameter int bus_timeout = 16
) (
   input  logic clk,
   input  logic reset,
   vmem_bus_if.bus bus,
   output logic wb_cyc,
   output logic wb_stb,
   output logic wb_we,
   output logic [vmem_pkg::phys_adr_bits-1:0] wb_adr,
   output logic [vmem_pkg::vma_width-1:0] wb_dat_w,
   input  logic [vmem_pkg::vma_width-1:0] wb_dat_r,
   input  logic wb_ack,
   input  vmem_pkg::md_word_u md,
   output vmem_pkg::md_word_u md_read,
   output logic md_valid
);

   localparam int timer_bits = $clog2(bus_timeout + 1);

   logic [timer_bits-1:0] timer;
   logic start;
   logic expired;

   // memrq stays up for a cycle after the end pulse, do not restart on it
   assign start = bus.memrq & ~wb_cyc & ~bus.memack & ~bus.bus_error;
   assign expired = (timer == timer_bits'(bus_timeout - 1));
   assign bus.busy = wb_cyc;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wb_cyc <= 1'b0;
         wb_stb <= 1'b0;
         bus.memack <= 1'b0;
         bus.bus_error <= 1'b0;
         md_valid <= 1'b0;
         timer <= '0;
      end
      else
      begin
         bus.memack <= 1'b0;
         bus.bus_error <= 1'b0;
         md_valid <= 1'b0;
         if (start)
         begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            timer <= '0;
         end
         else if (wb_cyc)
         begin
            if (wb_ack)
            begin
               wb_cyc <= 1'b0;
               wb_stb <= 1'b0;
               bus.memack <= 1'b1;
               md_valid <= 1'b1;
            end
            else if (expired)
            begin
               // no slave answered
               wb_cyc <= 1'b0;
               wb_stb <= 1'b0;
               bus.bus_error <= 1'b1;
            end
            else
               timer <= timer + 1'b1;
         end
      end
   end

   // write data follows md while idle and freezes once memrq is up
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         wb_we <= bus.wrcyc;
         wb_adr <= bus.phys_adr;
      end
      if (!wb_cyc && !bus.memrq)
         wb_dat_w <= md.raw;
      if (wb_cyc && wb_ack && !wb_we)
         md_read.raw <= wb_dat_r;
   end

   a_stb_cyc: assert property (@(posedge clk) disable iff (reset)
      wb_stb == wb_cyc);

   a_hold: assert property (@(posedge clk) disable iff (reset)
      wb_cyc && $past(wb_cyc) |-> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w));

endmodule

/* vmem_ctrl.sv */
// vmem control block with the phase sequencer, prepare/start/check chain, permit check and stall
`timescale 1ns/1ps

module vmem_ctrl (
   input  logic clk,
   input  logic reset,
   input  logic lcinc,
   input  logic needfetch,
   vmem_map_if.ctrl map,
   vmem_bus_if.ctrl bus,
   output logic vmaok,
   output logic waiting,
   output vmem_pkg::phase_t phase
);
   import vmem_pkg::*;

   logic memop;
   logic advance;
   logic memprepare;
   logic memstart;
   logic memcheck;
   logic memgo;
   logic memrq;
   logic mbusy;
   logic mfinish;
   logic rdcyc;
   logic wrcyc;
   logic pfr;
   logic pfw;
   logic acc_q;
   logic wr_q;
   logic [phys_adr_bits-1:0] adr_q;

   assign memop = map.memrd | map.memwr | map.ifetch;

   // the whole chain stalls with the machine cycle
   assign advance = ~waiting;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         memprepare <= 1'b0;
         memstart <= 1'b0;
         memcheck <= 1'b0;
      end
      else if (advance)
      begin
         memprepare <= (phase == alu || phase == write) ? memop : 1'b0;
         memstart <= (phase != alu) ? memprepare : 1'b0;
         memcheck <= memstart;
      end
   end

   // lookup result held for the check in the next alu phase
   always_ff @(posedge clk)
   begin
      if (advance && memstart)
      begin
         acc_q <= map.lvmo_23;
         wr_q <= map.lvmo_22;
         adr_q <= map.phys_adr;
      end
   end

   // permits
   assign pfr = acc_q & ~wrcyc;
   assign pfw = acc_q & wr_q & wrcyc;

   // last check cycle once the cycle type is known
   assign memgo = memcheck & ~memstart & (pfr | pfw);
   assign memrq = mbusy | memgo;
   assign mfinish = bus.memack | bus.bus_error | reset;

   always_ff @(posedge clk)
   begin
      if (reset)
         vmaok <= 1'b0;
      else if (memcheck && !memstart)
         vmaok <= pfr | pfw;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end
      else if (advance && (phase == fetch || phase == prefetch) && memstart && memcheck)
      begin
         rdcyc <= map.memrd | map.ifetch;
         wrcyc <= map.memwr;
      end
      else if ((!memrq && !memprepare && !memstart) || mfinish)
      begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (mfinish)
         mbusy <= 1'b0;
      else if (memgo)
         mbusy <= 1'b1;
   end

   // ifetch stall when the next instruction is needed
   assign waiting = (memrq & mbusy) | (lcinc & needfetch & mbusy);

   always_ff @(posedge clk)
   begin
      if (reset)
         phase <= alu;
      else if (!waiting)
      begin
         case (phase)
            alu: phase <= write;
            write: phase <= fetch;
            fetch: phase <= prefetch;
            default: phase <= alu;
         endcase
      end
   end

   assign bus.memrq = memrq;
   assign bus.wrcyc = wrcyc;
   assign bus.phys_adr = adr_q;

   a_cyc_onehot: assert property (@(posedge clk) disable iff (reset)
      !(rdcyc && wrcyc));

   a_memrq_held: assert property (@(posedge clk) disable iff (reset)
      memrq && !(bus.memack || bus.bus_error) |=> memrq);

   // bus cycle only inside a request
   a_busy_in_req: assert property (@(posedge clk) disable iff (reset)
      bus.busy |-> mbusy);

endmodule

/* vmem_map.sv */
// vmem map: two-level virtual to physical translation with map loading and permit bits
`timescale 1ns/1ps

module vmem_map (
   input  logic clk,
   input  logic reset,
   input  vmem_pkg::vma_word_u vma,
   input  vmem_pkg::md_word_u md,
   input  logic memrd,
   input  logic memwr,
   input  logic ifetch,
   input  logic map_wr_l1,
   input  logic map_wr_l2,
   vmem_map_if.map map
);
   import vmem_pkg::*;

   localparam int l1_depth = 2 ** l1_index_bits;
   localparam int l2_depth = 2 ** (l1_entry_bits + l2_index_bits);

   // level-1: block number per l1_index
   logic [l1_entry_bits-1:0] l1_tbl [l1_depth];

   // level-2: full entry per block and l2_index
   md_word_u l2_tbl [l2_depth];

   // access bits kept apart, one row per block, so a row clears in one cycle
   logic [2**l2_index_bits-1:0] acc_rows [2**l1_entry_bits];

   logic [l1_entry_bits-1:0] l1_out;
   logic [l1_entry_bits+l2_index_bits-1:0] l2_idx;
   md_word_u entry;
   logic acc_bit;
   logic clearing;
   logic [l1_entry_bits-1:0] clr_row;

   // lookup path
   assign l1_out = l1_tbl[vma.adr.l1_index];
   assign l2_idx = {l1_out, vma.adr.l2_index};
   assign entry = l2_tbl[l2_idx];
   assign acc_bit = acc_rows[l1_out][vma.adr.l2_index];

   // nothing is permitted until the access bits are cleared
   assign map.lvmo_23 = ~clearing & acc_bit;
   assign map.lvmo_22 = ~clearing & entry.map_entry.write;
   assign map.phys_adr = {entry.map_entry.page, vma.adr.offset};

   assign map.memrd = memrd;
   assign map.memwr = memwr;
   assign map.ifetch = ifetch;

   // walk all access rows after reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         clearing <= 1'b1;
         clr_row <= '0;
      end
      else if (clearing)
      begin
         clr_row <= clr_row + 1'b1;
         if (clr_row == '1)
            clearing <= 1'b0;
      end
   end

   // table writes, level-2 loads wait for the clear
   always_ff @(posedge clk)
   begin
      if (map_wr_l1)
         l1_tbl[vma.adr.l1_index] <= md.raw[l1_entry_bits-1:0];
      if (clearing)
         acc_rows[clr_row] <= '0;
      else if (map_wr_l2)
      begin
         acc_rows[l1_out][vma.adr.l2_index] <= md.map_entry.access;
         l2_tbl[l2_idx] <= md;
      end
   end

   // an access hit right after the clear means a row was missed
   a_clear_covers: assert property (@(posedge clk) disable iff (reset)
      map.lvmo_23 |-> !$past(clearing));

endmodule

/* vmem_if.sv */
// vmem interfaces: map lookup result to ctrl, and bus request between ctrl and bus
`timescale 1ns/1ps

interface vmem_map_if;
   import vmem_pkg::*;

   // permission bits of the current lookup
   logic lvmo_23;
   logic lvmo_22;
   logic [phys_adr_bits-1:0] phys_adr;

   // processor strobes, forwarded with the lookup
   logic memrd;
   logic memwr;
   logic ifetch;

   modport map (output lvmo_23, lvmo_22, phys_adr, memrd, memwr, ifetch);
   modport ctrl (input lvmo_23, lvmo_22, phys_adr, memrd, memwr, ifetch);

endinterface

interface vmem_bus_if;
   import vmem_pkg::*;

   // request side, memrq held until memack or bus_error
   logic memrq;
   logic wrcyc;
   logic [phys_adr_bits-1:0] phys_adr;

   // response side, memack and bus_error are one-cycle pulses
   logic memack;
   logic bus_error;
   logic busy;

   modport ctrl (output memrq, wrcyc, phys_adr, input memack, bus_error, busy);
   modport bus (input memrq, wrcyc, phys_adr, output memack, bus_error, busy);

endinterface

/* vmem_pkg.sv */
// vmem package: address widths, machine-cycle phase and the two decoded word views
package vmem_pkg;

   // one processor word, used for vma and md
   localparam int vma_width = 32;

   // virtual address fields, vma[23:13], vma[12:8] and vma[7:0]
   localparam int l1_index_bits = 11;
   localparam int l2_index_bits = 5;
   localparam int offset_bits = 8;

   // level-1 entry is the level-2 block number
   localparam int l1_entry_bits = 5;

   // physical page number held in a level-2 entry
   localparam int page_bits = 14;

   // page followed by offset, also the wishbone address width
   localparam int phys_adr_bits = page_bits + offset_bits;

   // machine-cycle phase, advanced once per edge unless stalled
   typedef enum logic [1:0] {
      alu,
      write,
      fetch,
      prefetch
   } phase_t;

   // level-2 map entry as it arrives on md
   typedef struct packed {
      logic [7:0] unused;
      logic access;
      logic write;
      logic [7:0] meta;
      logic [page_bits-1:0] page;
   } map_entry_t;

   // md is either bus data or a map entry
   typedef union packed {
      logic [vma_width-1:0] raw;
      map_entry_t map_entry;
   } md_word_u;

   // virtual address split into its table indices
   typedef struct packed {
      logic [7:0] unused;
      logic [l1_index_bits-1:0] l1_index;
      logic [l2_index_bits-1:0] l2_index;
      logic [offset_bits-1:0] offset;
   } vma_adr_t;

   typedef union packed {
      logic [vma_width-1:0] raw;
      vma_adr_t adr;
   } vma_word_u;

endpackage
